//--- list.f
+incdir+sim
source/overlay_pkg.sv
source/raster_if.sv
source/mark_if.sv
source/video_timing.sv
source/box_loader.sv
source/border_hit.sv
source/pixel_mixer.sv
source/box_overlay_top.sv
sim/tb_box_overlay.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_box_overlay
FILELIST  := list.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////
// box table mirror

overlay_pkg::box_t    m_box [NUM_BOXES];
logic [NUM_BOXES-1:0] m_valid = '0;     // nothing loaded after reset
logic [63:0]          m_asm;
int                   m_bytes = 0;
int                   m_idx   = 0;

task automatic model_byte(input logic [7:0] b);
    m_asm = {m_asm[55:0], b};           // msb first
    m_bytes++;
    if (m_bytes == overlay_pkg::BYTES_PER_BOX)
    begin
        m_bytes        = 0;
        m_box[m_idx]   = overlay_pkg::box_t'(m_asm);
        m_valid[m_idx] = 1'b1;
        m_idx          = (m_idx + 1) % NUM_BOXES;   // wrap at last slot
    end
endtask

//////////////////////////////
// border and colour rules

function automatic logic model_hit(input int h, input int v);
    int   m;
    int   x0;
    int   y0;
    int   x1;
    int   y1;
    logic hit;
    m   = overlay_pkg::BORDER_MARGIN;
    hit = 1'b0;
    for (int i = 0; i < NUM_BOXES; i++)
    begin
        x0 = int'(m_box[i].x0);
        y0 = int'(m_box[i].y0);
        x1 = int'(m_box[i].x1);
        y1 = int'(m_box[i].y1);
        if (m_valid[i] && (
            (h > x0 - m && h < x1 + m && v > y0 - m && v < y0 + m) ||   // top
            (h > x1 - m && h < x1 + m && v > y0 - m && v < y1 + m) ||   // right
            (h > x0 - m && h < x1 + m && v > y1 - m && v < y1 + m) ||   // bottom
            (h > x0 - m && h < x0 + m && v > y0 - m && v < y1 + m)))    // left
            hit = 1'b1;
    end
    return hit;
endfunction

function automatic logic [23:0] model_colour(input logic hit, input overlay_pkg::rgb565_t px);
    if (hit)
        return {overlay_pkg::MARK_R, overlay_pkg::MARK_G, overlay_pkg::MARK_B};
    return {px[15:11], 3'b000, px[10:5], 2'b00, px[4:0], 3'b000};
endfunction

`endif

//--- sim/tb_box_overlay.sv
`timescale 1ns/1ps

module tb_box_overlay;

    localparam int H_ACTIVE  = 24;
    localparam int H_FRONT   = 2;
    localparam int H_SYNC    = 3;
    localparam int H_BACK    = 3;
    localparam int V_ACTIVE  = 12;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 1;
    localparam int NUM_BOXES = 6;

    localparam int H_TOTAL     = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL     = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START    = H_ACTIVE + H_FRONT;
    localparam int VS_START    = V_ACTIVE + V_FRONT;
    localparam int RESET_CYC   = 10;
    localparam int LOAD_WINDOW = 100;       // fits inside vertical blanking
    localparam int TEST_FRAMES = 6;
    localparam int TIMEOUT_CYC = RESET_CYC + TEST_FRAMES * H_TOTAL * V_TOTAL
                               + 2 * LOAD_WINDOW + 200;

    logic                 pix_clk;
    logic                 rst_n_i;
    logic                 rx_valid_i;
    logic [7:0]           rx_byte_i;
    overlay_pkg::rgb565_t pix_rgb565_i;
    logic                 pix_req_o;
    logic                 vs_o;
    logic                 hs_o;
    logic                 de_o;
    logic [7:0]           r_o;
    logic [7:0]           g_o;
    logic [7:0]           b_o;

    `include "tb_model.svh"

    overlay_pkg::rgb565_t pix_q [$];        // requested background pixels
    overlay_pkg::rgb565_t next_px;
    overlay_pkg::rgb565_t out_px;
    overlay_pkg::rgb565_t held_px;
    logic [23:0]          exp_rgb;
    logic                 exp_hit;
    logic [31:0]          rng_state = 32'h6156eb87;
    int rast_h;
    int rast_v;
    int out_h;
    int out_v;
    int x_cnt;
    int y_cnt;
    int frames_done = 0;
    int mark_cnt    = 0;
    int cyc_cnt     = 0;
    logic de_q;
    logic vs_q;
    logic blank_ok;

    box_overlay_top #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
        .NUM_BOXES (NUM_BOXES)
    ) i_box_overlay_top (
        .pix_clk      (pix_clk),
        .rst_n_i      (rst_n_i),
        .rx_valid_i   (rx_valid_i),
        .rx_byte_i    (rx_byte_i),
        .pix_rgb565_i (pix_rgb565_i),
        .pix_req_o    (pix_req_o),
        .vs_o         (vs_o),
        .hs_o         (hs_o),
        .de_o         (de_o),
        .r_o          (r_o),
        .g_o          (g_o),
        .b_o          (b_o)
    );

    //////////////////////////////
    // helpers

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_rgb(input logic [7:0] er, eg, eb, ar, ag, ab);
        if ({er, eg, eb} !== {ar, ag, ab})
            fail_run($sformatf(
                "error at %0t: r_o/g_o/b_o expected %02h/%02h/%02h got %02h/%02h/%02h",
                $time, er, eg, eb, ar, ag, ab));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act)
            fail_run($sformatf("error at %0t: %s expected %b got %b", $time, name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act)
            fail_run($sformatf("error at %0t: %s expected %0d got %0d", $time, name, exp, act));
    endtask

    task automatic step_pos(inout int h, inout int v);
        if (h == H_TOTAL - 1)
        begin
            h = 0;
            v = (v == V_TOTAL - 1) ? 0 : v + 1;
        end
        else
            h = h + 1;
    endtask

    task automatic wait_frame_end();
        int seen;
        seen = frames_done;
        wait (frames_done != seen);
    endtask

    // records go out msb first with random idle cycles
    task automatic load_boxes(input int count, input logic edge_boxes);
        overlay_pkg::box_t bx;
        logic [31:0]       rnd;
        int                spare;
        spare = LOAD_WINDOW - count * overlay_pkg::BYTES_PER_BOX;
        for (int n = 0; n < count; n++)
        begin
            bx.x0 = overlay_pkg::coord_t'(xorshift32() % 32'd28);
            bx.y0 = overlay_pkg::coord_t'(xorshift32() % 32'd16);
            bx.x1 = overlay_pkg::coord_t'(xorshift32() % 32'd28);
            bx.y1 = overlay_pkg::coord_t'(xorshift32() % 32'd16);
            if (edge_boxes && n == 0)
            begin
                bx.x0 = '0;
                bx.y0 = '0;
            end
            if (edge_boxes && n == 1)
            begin
                bx.x0 = 16'd1;
                bx.y0 = 16'd1;
            end
            if (edge_boxes && n == 2)
            begin
                bx.x1 = 16'd1;                  // edges drawn near zero
                bx.y1 = '0;
            end
            for (int k = overlay_pkg::BYTES_PER_BOX - 1; k >= 0; k--)
            begin
                @(posedge pix_clk);
                rx_valid_i <= 1'b1;
                rx_byte_i  <= bx[8*k +: 8];
                model_byte(bx[8*k +: 8]);
                rnd = xorshift32();
                if (spare > 0 && rnd[0])
                begin
                    @(posedge pix_clk);
                    rx_valid_i <= 1'b0;
                    spare--;
                end
            end
        end
        @(posedge pix_clk);
        rx_valid_i <= 1'b0;
    endtask

    //////////////////////////////
    // clock, pixel source, timeout

    initial
    begin
        pix_clk = 1'b0;
        forever #5 pix_clk = ~pix_clk;
    end

    // pixels that answer a request are queued
    always @(posedge pix_clk)
    begin
        next_px = overlay_pkg::rgb565_t'(xorshift32());
        pix_rgb565_i <= next_px;
        if (rst_n_i && pix_req_o)
            pix_q.push_back(next_px);
    end

    always @(posedge pix_clk)
    begin
        cyc_cnt++;
        if (cyc_cnt > TIMEOUT_CYC)
            fail_run("timeout: the test frames did not finish in time");
    end

    //////////////////////////////
    // output monitor

    always @(negedge pix_clk)
    begin
        if (!rst_n_i)
        begin
            check_flag("pix_req_o", 1'b0, pix_req_o);
            check_flag("de_o", 1'b0, de_o);
            check_flag("hs_o", 1'b0, hs_o);
            check_flag("vs_o", 1'b0, vs_o);
            check_rgb(8'd0, 8'd0, 8'd0, r_o, g_o, b_o);
            rast_h   = H_TOTAL - 2;             // one step before the parked count
            rast_v   = V_TOTAL - 1;
            out_h    = H_TOTAL - 4;             // outputs lag the raster by two
            out_v    = V_TOTAL - 1;
            x_cnt    = 0;
            y_cnt    = 0;
            de_q     = 1'b0;
            vs_q     = 1'b0;
            blank_ok = 1'b0;
        end
        else
        begin
            step_pos(rast_h, rast_v);
            step_pos(out_h, out_v);
            check_flag("pix_req_o", (rast_h < H_ACTIVE) && (rast_v < V_ACTIVE), pix_req_o);
            check_flag("de_o", (out_h < H_ACTIVE) && (out_v < V_ACTIVE), de_o);
            check_flag("hs_o", (out_h >= HS_START) && (out_h < HS_START + H_SYNC), hs_o);
            check_flag("vs_o", (out_v >= VS_START) && (out_v < VS_START + V_SYNC), vs_o);
            if (de_o)
            begin
                if (pix_q.size() == 0)
                    fail_run("de_o was high with no background pixel requested for it");
                out_px  = pix_q.pop_front();
                exp_hit = model_hit(x_cnt, y_cnt);
                exp_rgb = model_colour(exp_hit, out_px);
                check_rgb(exp_rgb[23:16], exp_rgb[15:8], exp_rgb[7:0], r_o, g_o, b_o);
                if (exp_hit)
                    mark_cnt++;
                x_cnt++;
            end
            else if (de_q)
            begin
                check_count("pixels per line", H_ACTIVE, x_cnt);
                x_cnt = 0;
                y_cnt++;
                if (y_cnt == V_ACTIVE)
                begin
                    check_count("pending pixels at frame end", 0, pix_q.size());
                    frames_done++;
                end
            end
            if (!de_o && blank_ok)
            begin
                exp_rgb = model_colour(1'b0, held_px);  // blanking shows the background
                check_rgb(exp_rgb[23:16], exp_rgb[15:8], exp_rgb[7:0], r_o, g_o, b_o);
            end
            if (vs_o && !vs_q)
            begin
                check_count("lines per frame", V_ACTIVE, y_cnt);
                y_cnt = 0;
            end
            held_px  = pix_rgb565_i;            // registered at the next rising edge
            blank_ok = 1'b1;
            de_q     = de_o;
            vs_q     = vs_o;
        end
    end

    //////////////////////////////
    // test sequence

    initial
    begin
        rst_n_i      = 1'b0;
        rx_valid_i   = 1'b0;
        rx_byte_i    = '0;
        pix_rgb565_i = '0;
        repeat (RESET_CYC) @(posedge pix_clk);
        rst_n_i <= 1'b1;

        wait_frame_end();                       // plain background frame
        load_boxes(NUM_BOXES, 1'b1);
        wait_frame_end();
        wait_frame_end();
        load_boxes(NUM_BOXES + 2, 1'b0);        // overwrites slots 0 and 1 twice
        wait_frame_end();
        wait_frame_end();

        if (mark_cnt == 0)
            fail_run("no pixel was drawn in the outline colour");
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- source/box_overlay_top.sv
`timescale 1ns/1ps

module box_overlay_top #(
    parameter int H_ACTIVE  = 1280,
    parameter int H_FRONT   = 110,
    parameter int H_SYNC    = 40,
    parameter int H_BACK    = 220,
    parameter int V_ACTIVE  = 720,
    parameter int V_FRONT   = 5,
    parameter int V_SYNC    = 5,
    parameter int V_BACK    = 20,
    parameter int NUM_BOXES = 24
) (
    input  logic                 pix_clk,
    input  logic                 rst_n_i,
    input  logic                 rx_valid_i,   // one byte per strobe
    input  logic [7:0]           rx_byte_i,
    input  overlay_pkg::rgb565_t pix_rgb565_i, // cycle after pix_req_o
    output logic                 pix_req_o,
    output logic                 vs_o,
    output logic                 hs_o,
    output logic                 de_o,
    output logic [7:0]           r_o,
    output logic [7:0]           g_o,
    output logic [7:0]           b_o
);

    overlay_pkg::box_t    boxes [NUM_BOXES];
    logic [NUM_BOXES-1:0] box_valid;

    raster_if raster_bus ();
    mark_if   mark_bus ();

    //////////////////////////////
    // datapath

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) i_video_timing (
        .pix_clk   (pix_clk),
        .rst_n_i   (rst_n_i),
        .raster    (raster_bus.producer),
        .pix_req_o (pix_req_o)
    );

    box_loader #(
        .NUM_BOXES (NUM_BOXES)
    ) i_box_loader (
        .pix_clk     (pix_clk),
        .rst_n_i     (rst_n_i),
        .rx_valid_i  (rx_valid_i),
        .rx_byte_i   (rx_byte_i),
        .boxes_o     (boxes),
        .box_valid_o (box_valid)
    );

    border_hit #(
        .NUM_BOXES (NUM_BOXES)
    ) i_border_hit (
        .pix_clk     (pix_clk),
        .rst_n_i     (rst_n_i),
        .raster      (raster_bus.consumer),
        .boxes_i     (boxes),
        .box_valid_i (box_valid),
        .mark        (mark_bus.producer)
    );

    pixel_mixer i_pixel_mixer (
        .pix_clk      (pix_clk),
        .rst_n_i      (rst_n_i),
        .mark         (mark_bus.consumer),
        .pix_rgb565_i (pix_rgb565_i),
        .vs_o         (vs_o),
        .hs_o         (hs_o),
        .de_o         (de_o),
        .r_o          (r_o),
        .g_o          (g_o),
        .b_o          (b_o)
    );

endmodule

//--- source/pixel_mixer.sv
`timescale 1ns/1ps

module pixel_mixer (
    input  logic                 pix_clk,
    input  logic                 rst_n_i,
    mark_if.consumer             mark,
    input  overlay_pkg::rgb565_t pix_rgb565_i,
    output logic                 vs_o,
    output logic                 hs_o,
    output logic                 de_o,
    output logic [7:0]           r_o,
    output logic [7:0]           g_o,
    output logic [7:0]           b_o
);

    logic [7:0] r_c;
    logic [7:0] g_c;
    logic [7:0] b_c;

    always_comb
    begin
        if (mark.hit && mark.de)
        begin
            r_c = overlay_pkg::MARK_R;
            g_c = overlay_pkg::MARK_G;
            b_c = overlay_pkg::MARK_B;
        end
        else
        begin
            r_c = {pix_rgb565_i[15:11], 3'b000};    // zero fill
            g_c = {pix_rgb565_i[10:5],  2'b00};
            b_c = {pix_rgb565_i[4:0],   3'b000};
        end
    end

    always_ff @(posedge pix_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            vs_o <= 1'b0;
            hs_o <= 1'b0;
            de_o <= 1'b0;
            r_o  <= '0;
            g_o  <= '0;
            b_o  <= '0;
        end
        else
        begin
            vs_o <= mark.vs;
            hs_o <= mark.hs;
            de_o <= mark.de;
            r_o  <= r_c;
            g_o  <= g_c;
            b_o  <= b_c;
        end
    end

endmodule

//--- source/border_hit.sv
`timescale 1ns/1ps

module border_hit #(
    parameter int NUM_BOXES = 24
) (
    input  logic                 pix_clk,
    input  logic                 rst_n_i,
    raster_if.consumer           raster,
    input  overlay_pkg::box_t    boxes_i [NUM_BOXES],
    input  logic [NUM_BOXES-1:0] box_valid_i,
    mark_if.producer             mark
);

    // two extra bits keep bounds near 0 and near the top exact
    localparam int EXT_W = $bits(overlay_pkg::coord_t) + 2;

    localparam logic signed [EXT_W-1:0] MARGIN = EXT_W'(overlay_pkg::BORDER_MARGIN);

    logic [NUM_BOXES-1:0] box_hit;
    logic                 hit_c;

    // open interval (lo - m, hi + m)
    function automatic logic in_band(
        input overlay_pkg::coord_t p,
        input overlay_pkg::coord_t lo,
        input overlay_pkg::coord_t hi
    );
        logic signed [EXT_W-1:0] p_s;
        logic signed [EXT_W-1:0] lo_s;
        logic signed [EXT_W-1:0] hi_s;
        p_s  = signed'({2'b00, p});
        lo_s = signed'({2'b00, lo}) - MARGIN;
        hi_s = signed'({2'b00, hi}) + MARGIN;
        return (p_s > lo_s) && (p_s < hi_s);
    endfunction

    //////////////////////////////
    // per box edge test

    for (genvar i = 0; i < NUM_BOXES; i++)
    begin : g_box
        overlay_pkg::box_t b;
        logic              top_e;
        logic              right_e;
        logic              bottom_e;
        logic              left_e;

        assign b        = boxes_i[i];
        assign top_e    = in_band(raster.h_count, b.x0, b.x1)
                       && in_band(raster.v_count, b.y0, b.y0);
        assign right_e  = in_band(raster.h_count, b.x1, b.x1)
                       && in_band(raster.v_count, b.y0, b.y1);
        assign bottom_e = in_band(raster.h_count, b.x0, b.x1)
                       && in_band(raster.v_count, b.y1, b.y1);
        assign left_e   = in_band(raster.h_count, b.x0, b.x0)
                       && in_band(raster.v_count, b.y0, b.y1);

        assign box_hit[i] = box_valid_i[i] && (top_e || right_e || bottom_e || left_e);
    end

    assign hit_c = |box_hit;

    //////////////////////////////
    // output stage

    always_ff @(posedge pix_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            mark.hit <= 1'b0;
            mark.de  <= 1'b0;
            mark.hs  <= 1'b0;
            mark.vs  <= 1'b0;
        end
        else
        begin
            mark.hit <= hit_c;
            mark.de  <= raster.de;      // syncs follow the mark
            mark.hs  <= raster.hs;
            mark.vs  <= raster.vs;
        end
    end

endmodule

//--- source/box_loader.sv
`timescale 1ns/1ps

module box_loader #(
    parameter int NUM_BOXES = 24
) (
    input  logic                pix_clk,
    input  logic                rst_n_i,
    input  logic                rx_valid_i,
    input  logic [7:0]          rx_byte_i,
    output overlay_pkg::box_t   boxes_o [NUM_BOXES],
    output logic [NUM_BOXES-1:0] box_valid_o
);

    localparam int IDX_W = (NUM_BOXES > 1) ? $clog2(NUM_BOXES) : 1;
    localparam int CNT_W = $clog2(overlay_pkg::BYTES_PER_BOX);
    localparam int REC_W = $bits(overlay_pkg::box_t);

    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(NUM_BOXES - 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(overlay_pkg::BYTES_PER_BOX - 1);

    overlay_pkg::box_t  asm_q;
    overlay_pkg::box_t  asm_next;
    overlay_pkg::box_t  box_tab [NUM_BOXES];
    logic [CNT_W-1:0]   byte_cnt;
    logic [IDX_W-1:0]   box_idx;
    logic               rec_done;

    assign asm_next = {asm_q[REC_W-9:0], rx_byte_i};   // newest byte at the bottom
    assign rec_done = rx_valid_i && (byte_cnt == CNT_LAST);

    always_ff @(posedge pix_clk)
    begin
        if (rx_valid_i)
            asm_q <= asm_next;
        if (rec_done)
            box_tab[box_idx] <= asm_next;
    end

    always_ff @(posedge pix_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            byte_cnt    <= '0;
            box_idx     <= '0;
            box_valid_o <= '0;          // nothing drawn until loaded
        end
        else if (rx_valid_i)
        begin
            if (rec_done)
            begin
                byte_cnt             <= '0;
                box_valid_o[box_idx] <= 1'b1;
                box_idx              <= (box_idx == IDX_LAST) ? '0 : box_idx + 1'b1;
            end
            else
                byte_cnt <= byte_cnt + 1'b1;
        end
    end

    assign boxes_o = box_tab;

endmodule

//--- source/video_timing.sv
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BACK   = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT  = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BACK   = 20
) (
    input  logic        pix_clk,
    input  logic        rst_n_i,
    raster_if.producer  raster,
    output logic        pix_req_o
);

    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int HS_END   = HS_START + H_SYNC;
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int VS_END   = VS_START + V_SYNC;

    localparam overlay_pkg::coord_t H_LAST = overlay_pkg::coord_t'(H_TOTAL - 1);
    localparam overlay_pkg::coord_t V_LAST = overlay_pkg::coord_t'(V_TOTAL - 1);

    overlay_pkg::coord_t h_cnt;
    overlay_pkg::coord_t v_cnt;
    logic                line_end;

    assign line_end = (h_cnt == H_LAST);

    //////////////////////////////
    // counters

    // reset parks both counters on the last back porch position,
    // so the first advance after release lands on pixel 0 of line 0
    always_ff @(posedge pix_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            h_cnt <= H_LAST;
            v_cnt <= V_LAST;
        end
        else
        begin
            if (line_end)
                h_cnt <= '0;
            else
                h_cnt <= h_cnt + 1'b1;

            if (line_end)
            begin
                if (v_cnt == V_LAST)
                    v_cnt <= '0;                // frame wrap
                else
                    v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////
    // decode

    assign raster.h_count = h_cnt;
    assign raster.v_count = v_cnt;
    assign raster.de      = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
    assign raster.hs      = (h_cnt >= HS_START) && (h_cnt < HS_END);
    assign raster.vs      = (v_cnt >= VS_START) && (v_cnt < VS_END);  // whole lines

    assign pix_req_o = raster.de;   // one background pixel per active position

endmodule

//--- source/mark_if.sv
`timescale 1ns/1ps

// border mark with syncs, one cycle behind the raster
interface mark_if;

    logic hit;      // pixel lies on a box edge
    logic de;
    logic hs;
    logic vs;

    modport producer (
        output hit, de, hs, vs
    );

    modport consumer (
        input hit, de, hs, vs
    );

endinterface

//--- source/raster_if.sv
`timescale 1ns/1ps

// raster position and syncs, all valid in the same cycle
interface raster_if;

    overlay_pkg::coord_t h_count;
    overlay_pkg::coord_t v_count;
    logic                de;     // active video
    logic                hs;
    logic                vs;

    modport producer (
        output h_count, v_count, de, hs, vs
    );

    modport consumer (
        input h_count, v_count, de, hs, vs
    );

endinterface

//--- source/overlay_pkg.sv
package overlay_pkg;

    //////////////////////////////
    // basic types

    localparam int COORD_W = 16;

    typedef logic [COORD_W-1:0] coord_t;    // pixel or line number

    // one box record, x0 is the first field received
    typedef struct packed {
        coord_t x0;                         // left
        coord_t y0;                         // top
        coord_t x1;                         // right
        coord_t y1;                         // bottom
    } box_t;

    typedef logic [15:0] rgb565_t;          // r 15:11, g 10:5, b 4:0

    //////////////////////////////
    // overlay constants

    localparam int BYTES_PER_BOX = 8;       // msb first on the byte stream
    localparam int BORDER_MARGIN = 2;       // half width of an edge

    // outline colour
    localparam logic [7:0] MARK_R = 8'd255;
    localparam logic [7:0] MARK_G = 8'd0;
    localparam logic [7:0] MARK_B = 8'd0;

endpackage
